/* bus_merge.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ext_mem_consts.svh"

module bus_merge (
   input  logic      clk,
   input  logic      arst_n,
   mem_bus_if.slave  m,      // Instruction cache
   mem_bus_if.slave  d,      // Data cache
   mem_bus_if.master s
);

   logic [`N_MASTERS-1:0] req_v;
   logic [`GRANT_W-1:0]   grant;     // Locked master, or priority when idle
   logic [`GRANT_W-1:0]   sel;
   logic                  busy;

   assign req_v = {d.valid, m.valid};

   // Round-robin pick at idle, locked while a request is outstanding
   always_comb begin
      if (busy || req_v[grant] || !req_v[~grant])
         sel = grant;
      else
         sel = ~grant;
   end

   always_comb begin
      if (sel == '0) begin
         s.valid = m.valid;
         s.addr  = m.addr;
         s.wdata = m.wdata;
         s.wstrb = m.wstrb;
      end else begin
         s.valid = d.valid;
         s.addr  = d.addr;
         s.wdata = d.wdata;
         s.wstrb = d.wstrb;
      end
   end

   // Response only to the granted master
   assign m.ready = s.ready && (sel == '0);
   assign d.ready = s.ready && (sel != '0);
   assign m.rdata = (sel == '0) ? s.rdata : '0;
   assign d.rdata = (sel != '0) ? s.rdata : '0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         grant <= '0;                  // icache first
         busy  <= 1'b0;
      end else if (s.ready) begin
         busy  <= 1'b0;
         grant <= ~sel;                // Other master next
      end else if (s.valid) begin
         busy  <= 1'b1;
         grant <= sel;
      end
   end

endmodule

`default_nettype wire

/* ext_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module ext_mem (
   input  logic               clk,
   input  logic               arst_n,

   // Instruction port
   input  logic               i_valid,
   input  ext_mem_pkg::addr_t i_addr,
   input  ext_mem_pkg::word_t i_wdata,
   input  ext_mem_pkg::strb_t i_wstrb,
   output ext_mem_pkg::word_t i_rdata,
   output logic               i_ready,

   // Data port
   input  logic               d_valid,
   input  ext_mem_pkg::addr_t d_addr,
   input  ext_mem_pkg::word_t d_wdata,
   input  ext_mem_pkg::strb_t d_wstrb,
   output ext_mem_pkg::word_t d_rdata,
   output logic               d_ready,

   // External memory
   output logic               mem_valid,
   output ext_mem_pkg::addr_t mem_addr,
   output ext_mem_pkg::word_t mem_wdata,
   output ext_mem_pkg::strb_t mem_wstrb,
   input  ext_mem_pkg::word_t mem_rdata,
   input  logic               mem_ready
);

   mem_bus_if icache_be ();
   mem_bus_if dcache_be ();
   mem_bus_if merged_be ();

   l1_cache icache (
      .clk    (clk),
      .arst_n (arst_n),
      .valid  (i_valid),
      .addr   (i_addr),
      .wdata  (i_wdata),
      .wstrb  (i_wstrb),      // Tied off by the requester
      .rdata  (i_rdata),
      .ready  (i_ready),
      .be     (icache_be)
   );

   l1_cache dcache (
      .clk    (clk),
      .arst_n (arst_n),
      .valid  (d_valid),
      .addr   (d_addr),
      .wdata  (d_wdata),
      .wstrb  (d_wstrb),
      .rdata  (d_rdata),
      .ready  (d_ready),
      .be     (dcache_be)
   );

   bus_merge merge_i_d_buses (
      .clk    (clk),
      .arst_n (arst_n),
      .m      (icache_be),
      .d      (dcache_be),
      .s      (merged_be)
   );

   assign mem_valid       = merged_be.valid;
   assign mem_addr        = merged_be.addr;
   assign mem_wdata       = merged_be.wdata;
   assign mem_wstrb       = merged_be.wstrb;
   assign merged_be.rdata = mem_rdata;
   assign merged_be.ready = mem_ready;

endmodule

`default_nettype wire

/* ext_mem_consts.svh */
`ifndef EXT_MEM_CONSTS_SVH
`define EXT_MEM_CONSTS_SVH

// Native bus widths
`define ADDR_W          16
`define DATA_W          32
`define STRB_W          (`DATA_W/8)

// L1 line geometry
`define LINE_OFF_W      3                  // 8 lines
`define WORD_OFF_W      2                  // 4 words per line
`define BYTE_OFF_W      2
`define TAG_W           (`ADDR_W-`LINE_OFF_W-`WORD_OFF_W-`BYTE_OFF_W)

`define N_LINES         (1 << `LINE_OFF_W)
`define WORDS_PER_LINE  (1 << `WORD_OFF_W)

// Merge arbiter
`define N_MASTERS       2                  // icache and dcache
`define GRANT_W         $clog2(`N_MASTERS)

`endif

/* ext_mem_pkg.sv */
`default_nettype none

`include "ext_mem_consts.svh"

package ext_mem_pkg;

   typedef logic [`ADDR_W-1:0] addr_t;    // Byte address
   typedef logic [`DATA_W-1:0] word_t;
   typedef logic [`STRB_W-1:0] strb_t;

   // Address split as seen by a direct-mapped L1
   typedef struct packed {
      logic [`TAG_W-1:0]      tag;
      logic [`LINE_OFF_W-1:0] index;
      logic [`WORD_OFF_W-1:0] word;
      logic [`BYTE_OFF_W-1:0] byte_off;
   } cache_fields_t;

   // Flat bus view or cache view of the same address
   typedef union packed {
      addr_t         flat;
      cache_fields_t fields;
   } cache_addr_t;

endpackage

`default_nettype wire

/* ext_mem_stim.txt */
# Memory init: the word at word address a holds a ^ 32'hA5A50000
# Columns: name port(I/D/B) op(R/W) addr wdata wstrb exp_rdata exp_reads
# Port B: the data side reads addr ^ 8000 and expects the init word there
# Write lines do not use exp_rdata
d_rd_miss     D R 0100 00000000 0 A5A50040 4
d_rd_hit      D R 010C 00000000 0 A5A50043 0
d_rd_hit2     D R 0104 00000000 0 A5A50041 0
d_wr_hit      D W 0108 11223344 3 00000000 0
d_rd_merged   D R 0108 00000000 0 A5A53344 0
d_wr_miss     D W 0234 CAFEBABE C 00000000 0
d_rd_wmiss    D R 0234 00000000 0 CAFE008D 4
i_rd_miss     I R 0400 00000000 0 A5A50100 4
i_rd_hit      I R 0408 00000000 0 A5A50102 0
i_rd_dwrite   I R 0108 00000000 0 A5A53344 4
i_rd_dwrite2  I R 0234 00000000 0 CAFE008D 4
evict_a       D R 0500 00000000 0 A5A50140 4
evict_b       D R 0580 00000000 0 A5A50160 4
evict_a2      D R 0500 00000000 0 A5A50140 4
evict_a_hit   D R 0504 00000000 0 A5A50141 0
both_miss     B R 0600 00000000 0 A5A50180 8
both_miss2    B R 0A7C 00000000 0 A5A5029F 8
both_hit      B R 0A70 00000000 0 A5A5029C 0
i_rd_after_b  I R 0604 00000000 0 A5A50181 0
d_wr_byte     D W 8A78 000000EE 1 00000000 0
d_rd_byte     D R 8A78 00000000 0 A5A522EE 0
i_rd_hit2     I R 0A78 00000000 0 A5A5029E 0

/* l1_cache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ext_mem_consts.svh"

module l1_cache (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               valid,
   input  ext_mem_pkg::addr_t addr,
   input  ext_mem_pkg::word_t wdata,
   input  ext_mem_pkg::strb_t wstrb,
   output ext_mem_pkg::word_t rdata,
   output logic               ready,
   mem_bus_if.master          be
);
   import ext_mem_pkg::*;

   typedef enum logic [1:0] {
      IDLE,      // Ready cycle, finished request still on the port
      LOOKUP,    // Waits for a request and compares tags
      REFILL,
      WRITE
   } state_t;

   state_t                 state;
   logic [`WORD_OFF_W-1:0] cnt;         // Refill beat
   logic [`N_LINES-1:0]    line_vld;

   word_t                  data_mem [`N_LINES][`WORDS_PER_LINE];
   logic [`TAG_W-1:0]      tag_mem  [`N_LINES];

   cache_addr_t            fe_a;        // Live front-end address
   cache_addr_t            req_a;       // Request being served
   cache_addr_t            start_a;     // First refill address
   cache_addr_t            next_a;      // Following refill address

   logic                   be_valid;
   addr_t                  be_addr;
   word_t                  be_wdata;
   strb_t                  be_wstrb;

   logic                   accept;
   logic                   is_wr;
   logic                   hit;
   logic                   rd_hit;
   logic                   rd_miss;
   logic                   wr_req;
   logic                   fill_beat;
   logic                   fill_last;
   logic                   wr_done;
   word_t                  merged;

   assign fe_a.flat = addr;

   assign accept    = (state == LOOKUP) && valid;
   assign is_wr     = |wstrb;
   assign hit       = line_vld[fe_a.fields.index] &&
                      (tag_mem[fe_a.fields.index] == fe_a.fields.tag);
   assign rd_hit    = accept && !is_wr && hit;
   assign rd_miss   = accept && !is_wr && !hit;
   assign wr_req    = accept && is_wr;
   assign fill_beat = (state == REFILL) && be.ready;
   assign fill_last = fill_beat && (cnt == `WORD_OFF_W'(`WORDS_PER_LINE-1));
   assign wr_done   = (state == WRITE) && be.ready;

   // Refill bursts start at word 0 of the line
   always_comb begin
      start_a.fields = '{tag: fe_a.fields.tag, index: fe_a.fields.index,
                         word: '0, byte_off: '0};
      next_a.fields  = '{tag: req_a.fields.tag, index: req_a.fields.index,
                         word: cnt + 1'b1, byte_off: '0};
   end

   // Write data merged into the stored word under the strobes
   always_comb begin
      merged = data_mem[fe_a.fields.index][fe_a.fields.word];
      for (int b = 0; b < `STRB_W; b++) begin
         if (wstrb[b])
            merged[8*b +: 8] = wdata[8*b +: 8];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IDLE;
         ready    <= 1'b0;
         be_valid <= 1'b0;
         cnt      <= '0;
         line_vld <= '0;
      end else begin
         ready <= rd_hit | fill_last | wr_done;   // Single-cycle pulse
         case (state)
            IDLE: state <= LOOKUP;
            LOOKUP: begin
               if (rd_hit) begin
                  state <= IDLE;
               end else if (rd_miss) begin
                  state    <= REFILL;
                  be_valid <= 1'b1;
                  cnt      <= '0;
               end else if (wr_req) begin
                  state    <= WRITE;                // No write-allocate
                  be_valid <= 1'b1;
               end
            end
            REFILL: begin
               if (fill_beat)
                  cnt <= cnt + 1'b1;
               if (fill_last) begin
                  be_valid                     <= 1'b0;
                  line_vld[req_a.fields.index] <= 1'b1;
                  state                        <= IDLE;
               end
            end
            WRITE: begin
               if (wr_done) begin
                  be_valid <= 1'b0;
                  state    <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         req_a <= fe_a;
      if (rd_hit)
         rdata <= data_mem[fe_a.fields.index][fe_a.fields.word];
      if (rd_miss) begin
         be_addr  <= start_a.flat;
         be_wstrb <= '0;
      end
      if (wr_req) begin
         be_addr  <= fe_a.flat;
         be_wdata <= wdata;
         be_wstrb <= wstrb;
         if (hit)
            data_mem[fe_a.fields.index][fe_a.fields.word] <= merged;
      end
      if (fill_beat) begin
         data_mem[req_a.fields.index][cnt] <= be.rdata;
         be_addr                           <= next_a.flat;
         if (cnt == req_a.fields.word)
            rdata <= be.rdata;                     // Requested word on the fly
      end
      if (fill_last)
         tag_mem[req_a.fields.index] <= req_a.fields.tag;
   end

   assign be.valid = be_valid;
   assign be.addr  = be_addr;
   assign be.wdata = be_wdata;
   assign be.wstrb = be_wstrb;

endmodule

`default_nettype wire

/* mem_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;
   import ext_mem_pkg::*;

   logic  valid;
   addr_t addr;
   word_t wdata;
   strb_t wstrb;     // Zero means read
   word_t rdata;
   logic  ready;     // One-cycle pulse per request

   modport master (
      output valid, addr, wdata, wstrb,
      input  rdata, ready
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output rdata, ready
   );

endinterface

`default_nettype wire

/* project.f */
+incdir+.
ext_mem_pkg.sv
mem_bus_if.sv
l1_cache.sv
bus_merge.sv
ext_mem.sv
tb_ext_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_ext_mem -o sim_ext_mem
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output="$(./obj_dir/sim_ext_mem)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
   exit 0
fi

echo "Simulation did not report a pass"
exit 1

/* tb_ext_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ext_mem_consts.svh"

module tb_ext_mem;
   import ext_mem_pkg::*;

   localparam int    MEM_WORDS   = 1 << (`ADDR_W - 2);
   localparam int    SEED        = 30177;
   localparam int    MAX_RECS    = 64;
   localparam int    CYC_PER_REC = 64;      // Cycle budget per stim line
   localparam string STIM_FILE   = "ext_mem_stim.txt";

   logic  clk;
   logic  arst_n;
   logic  i_valid;
   addr_t i_addr;
   word_t i_wdata;
   strb_t i_wstrb;
   word_t i_rdata;
   logic  i_ready;
   logic  d_valid;
   addr_t d_addr;
   word_t d_wdata;
   strb_t d_wstrb;
   word_t d_rdata;
   logic  d_ready;
   logic  mem_valid;
   addr_t mem_addr;
   word_t mem_wdata;
   strb_t mem_wstrb;
   word_t mem_rdata;
   logic  mem_ready;

   // Memory model
   word_t ram [MEM_WORDS];
   int    rd_count;
   int    wr_count;
   addr_t read_log [$];                     // Byte address of each back-end read
   addr_t last_wr_addr;
   word_t last_wr_data;
   strb_t last_wr_strb;

   // Stimulus records
   logic [8*16-1:0] rec_name  [MAX_RECS];
   logic [7:0]      rec_port  [MAX_RECS];
   logic [7:0]      rec_op    [MAX_RECS];
   addr_t           rec_addr  [MAX_RECS];
   word_t           rec_wdata [MAX_RECS];
   strb_t           rec_wstrb [MAX_RECS];
   word_t           rec_exp   [MAX_RECS];
   int              rec_reads [MAX_RECS];
   int              n_recs;

   int errors;
   int test_errs;
   int tests_run;
   int tests_passed;
   int cycles;
   int limit;

   ext_mem i_ext_mem (
      .clk       (clk),
      .arst_n    (arst_n),
      .i_valid   (i_valid),
      .i_addr    (i_addr),
      .i_wdata   (i_wdata),
      .i_wstrb   (i_wstrb),
      .i_rdata   (i_rdata),
      .i_ready   (i_ready),
      .d_valid   (d_valid),
      .d_addr    (d_addr),
      .d_wdata   (d_wdata),
      .d_wstrb   (d_wstrb),
      .d_rdata   (d_rdata),
      .d_ready   (d_ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   // Initial memory word for a word address
   function automatic word_t pattern_word(input logic [`ADDR_W-3:0] wa);
      return {{(`DATA_W-`ADDR_W+2){1'b0}}, wa} ^ 32'hA5A5_0000;
   endfunction

   task automatic compare_values(input logic [8*16-1:0] name, input logic [31:0] expected,
                                 input logic [31:0] actual);
      if (expected !== actual) begin
         $display("MISMATCH %0s: expected %h, actual %h", name, expected, actual);
         errors++;
         test_errs++;
      end
   endtask

   task automatic report_test(input logic [8*16-1:0] name);
      tests_run++;
      if (test_errs == 0) begin
         tests_passed++;
         $display("%0s: pass", name);
      end else begin
         $display("%0s: FAIL with %0d errors", name, test_errs);
      end
   endtask

   task automatic read_stimulus();
      int              fd;
      int              code;
      string           line;
      logic [8*16-1:0] name;
      logic [7:0]      port;
      logic [7:0]      op;
      addr_t           a;
      word_t           wd;
      strb_t           ws;
      word_t           ex;
      int              nrd;
      n_recs = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file %s", STIM_FILE);
         errors++;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
               code = $sscanf(line, "%s %s %s %h %h %h %h %d",
                              name, port, op, a, wd, ws, ex, nrd);
               if (code != 8 || n_recs >= MAX_RECS) begin
                  $display("Stimulus line could not be used: %s", line);
                  errors++;
               end else begin
                  rec_name[n_recs]  = name;
                  rec_port[n_recs]  = port;
                  rec_op[n_recs]    = op;
                  rec_addr[n_recs]  = a;
                  rec_wdata[n_recs] = wd;
                  rec_wstrb[n_recs] = ws;
                  rec_exp[n_recs]   = ex;
                  rec_reads[n_recs] = nrd;
                  n_recs++;
               end
            end
         end
         $fclose(fd);
         if (n_recs == 0) begin
            $display("The stimulus file holds no test lines");
            errors++;
         end
      end
   endtask

   // One request on either port or both until every used port gives ready
   task automatic run_access(input logic use_i, input logic use_d, input addr_t ia,
                             input addr_t da, input word_t wd, input strb_t ws,
                             output word_t i_got, output word_t d_got);
      logic i_wait;
      logic d_wait;
      i_wait = use_i;
      d_wait = use_d;
      i_got  = '0;
      d_got  = '0;
      @(posedge clk);
      #2;
      i_valid = use_i;
      i_addr  = ia;
      d_valid = use_d;
      d_addr  = da;
      d_wdata = wd;
      d_wstrb = ws;
      while (i_wait || d_wait) begin
         @(posedge clk);
         #2;
         if (i_wait && i_ready) begin
            i_got   = i_rdata;
            i_valid = 1'b0;
            i_wait  = 1'b0;
         end
         if (d_wait && d_ready) begin
            d_got   = d_rdata;
            d_valid = 1'b0;
            d_wait  = 1'b0;
         end
      end
   endtask

   // Line burst must be words 0 to 3 in order and nothing else from that line
   task automatic verify_burst(input logic [8*16-1:0] name, input addr_t line_addr,
                               input int from);
      int    n;
      addr_t want;
      n = 0;
      for (int k = from; k < read_log.size(); k++) begin
         if (read_log[k][`ADDR_W-1:4] == line_addr[`ADDR_W-1:4]) begin
            want = {line_addr[`ADDR_W-1:4], n[1:0], 2'b00};
            compare_values(name, 32'(want), 32'(read_log[k]));
            n++;
         end
      end
      compare_values(name, `WORDS_PER_LINE, n);
   endtask

   task automatic watch_reset_idle();
      test_errs = 0;
      for (int c = 0; c < 5; c++) begin
         @(posedge clk);
         #2;
         compare_values("reset_idle", 32'd0, {29'd0, i_ready, d_ready, mem_valid});
      end
      report_test("reset_idle");
   endtask

   initial begin : clock_gen
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin : memory_model
      int          countdown;
      logic [`ADDR_W-3:0] wa;
      void'($urandom(SEED));
      for (int a = 0; a < MEM_WORDS; a++)
         ram[a] = pattern_word(a[`ADDR_W-3:0]);
      mem_ready = 1'b0;
      mem_rdata = '0;
      rd_count  = 0;
      wr_count  = 0;
      countdown = -1;                       // No request pending
      forever begin
         @(posedge clk);
         #2;
         mem_ready = 1'b0;
         if (countdown < 0 && mem_valid)
            countdown = int'($urandom % 4); // Ready after 1 to 4 cycles
         if (countdown == 0) begin
            wa = mem_addr[`ADDR_W-1:2];
            if (mem_wstrb == '0) begin
               mem_rdata = ram[wa];
               read_log.push_back(mem_addr);
               rd_count++;
            end else begin
               for (int b = 0; b < `STRB_W; b++) begin
                  if (mem_wstrb[b])
                     ram[wa][8*b +: 8] = mem_wdata[8*b +: 8];
               end
               last_wr_addr = mem_addr;
               last_wr_data = mem_wdata;
               last_wr_strb = mem_wstrb;
               wr_count++;
            end
            mem_ready = 1'b1;
            countdown = -1;
         end else if (countdown > 0) begin
            countdown--;
         end
      end
   end

   initial begin : watchdog
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (limit == 0 || cycles < limit);
      $display("Timeout: the DUT did not finish the tests within %0d cycles", limit);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin : main
      logic [8*16-1:0] name;
      word_t           i_got;
      word_t           d_got;
      addr_t           da;
      logic            use_i;
      logic            use_d;
      logic            is_wr;
      int              rd0;
      int              wr0;
      int              log0;
      errors       = 0;
      tests_run    = 0;
      tests_passed = 0;
      limit        = 0;
      arst_n  = 1'b0;
      i_valid = 1'b0;
      i_addr  = '0;
      i_wdata = '0;
      i_wstrb = '0;                         // Instruction side never writes
      d_valid = 1'b0;
      d_addr  = '0;
      d_wdata = '0;
      d_wstrb = '0;
      read_stimulus();
      limit = n_recs * CYC_PER_REC;
      repeat (3) @(posedge clk);
      #2;
      arst_n = 1'b1;
      watch_reset_idle();
      for (int t = 0; t < n_recs; t++) begin
         name      = rec_name[t];
         test_errs = 0;
         use_i = (rec_port[t] == "I") || (rec_port[t] == "B");
         use_d = (rec_port[t] == "D") || (rec_port[t] == "B");
         is_wr = (rec_op[t] == "W");
         // Paired D request takes another tag on the same index
         da    = (rec_port[t] == "B") ? (rec_addr[t] ^ 16'h8000) : rec_addr[t];
         rd0   = rd_count;
         wr0   = wr_count;
         log0  = read_log.size();
         run_access(use_i, use_d, rec_addr[t], da, rec_wdata[t],
                    is_wr ? rec_wstrb[t] : '0, i_got, d_got);
         compare_values(name, rec_reads[t], rd_count - rd0);
         if (is_wr) begin
            compare_values(name, 32'd1, wr_count - wr0);
            compare_values(name, 32'(rec_addr[t]), 32'(last_wr_addr));
            compare_values(name, rec_wdata[t], last_wr_data);
            compare_values(name, 32'(rec_wstrb[t]), 32'(last_wr_strb));
         end else begin
            compare_values(name, 32'd0, wr_count - wr0);
            if (use_i)
               compare_values(name, rec_exp[t], i_got);
            if (use_d && rec_port[t] == "B")
               compare_values(name, pattern_word(da[`ADDR_W-1:2]), d_got);
            else if (use_d)
               compare_values(name, rec_exp[t], d_got);
            if (rec_reads[t] != 0 && use_i)
               verify_burst(name, rec_addr[t], log0);
            if (rec_reads[t] != 0 && use_d)
               verify_burst(name, da, log0);
         end
         report_test(name);
      end
      $display("Tests run: %0d, passed: %0d, errors: %0d", tests_run, tests_passed, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
